//--- hw/dc_corrector_top.sv
// Chroma DC corrector top level
`timescale 1ns/1ps
`default_nettype none

module dc_corrector_top import dc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  quant_cfg_t cfg,
    input  logic       in_valid,
    input  mb_in_t     in_mb,
    output logic       in_credit,
    output logic       out_valid,
    output mb_out_t    out_mb,
    input  logic       out_credit
);

    logic      rd_en;
    logic      wr_en;
    logic      first_row;
    mb_col_t   col;
    chan_err_t top_errs [2];
    chan_err_t left_errs [2];
    chan_err_t new_top [2];
    chan_err_t new_left [2];
    logic      q_enable;
    coeff_t    q_coeff_u;
    coeff_t    q_coeff_v;
    derr_t     q_top_u;
    derr_t     q_left_u;
    derr_t     q_top_v;
    derr_t     q_left_v;
    coeff_t    q_level_u;
    coeff_t    q_level_v;
    derr_t     q_err_u;
    derr_t     q_err_v;
    logic      result_push;
    mb_out_t   result;
    logic      slot_free;

    dc_diffuse_ctrl ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_mb       (in_mb),
        .in_credit   (in_credit),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .first_row   (first_row),
        .col         (col),
        .top_errs    (top_errs),
        .left_errs   (left_errs),
        .new_top     (new_top),
        .new_left    (new_left),
        .q_enable    (q_enable),
        .q_coeff_u   (q_coeff_u),
        .q_coeff_v   (q_coeff_v),
        .q_top_u     (q_top_u),
        .q_left_u    (q_left_u),
        .q_top_v     (q_top_v),
        .q_left_v    (q_left_v),
        .q_level_u   (q_level_u),
        .q_level_v   (q_level_v),
        .q_err_u     (q_err_u),
        .q_err_v     (q_err_v),
        .result_push (result_push),
        .result      (result),
        .slot_free   (slot_free)
    );

    dc_err_store err_store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .rd_col    (col),
        .top_errs  (top_errs),
        .left_errs (left_errs),
        .wr_en     (wr_en),
        .wr_col    (col),
        .new_top   (new_top),
        .new_left  (new_left),
        .first_row (first_row)
    );

    // U and V run side by side
    dc_quant_unit quant_u_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (q_enable),
        .coeff    (q_coeff_u),
        .top_err  (q_top_u),
        .left_err (q_left_u),
        .cfg      (cfg),
        .level    (q_level_u),
        .err      (q_err_u)
    );

    dc_quant_unit quant_v_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (q_enable),
        .coeff    (q_coeff_v),
        .top_err  (q_top_v),
        .left_err (q_left_v),
        .cfg      (cfg),
        .level    (q_level_v),
        .err      (q_err_v)
    );

    dc_credit_port credit_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .result_push (result_push),
        .result      (result),
        .slot_free   (slot_free),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_mb      (out_mb)
    );

endmodule

`default_nettype wire

//--- hw/dc_credit_port.sv
// Output slot with credit counter
`timescale 1ns/1ps
`default_nettype none

module dc_credit_port import dc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    result_push,
    input  mb_out_t result,
    output logic    slot_free,
    input  logic    out_credit,
    output logic    out_valid,
    output mb_out_t out_mb
);

    credit_cnt_t credits;
    logic        full;

    assign slot_free = !full;
    // Leaves as soon as a credit is held
    assign out_valid = full && (credits != '0);

    always_ff @(posedge clk) begin
        if (result_push) begin
            out_mb <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= '0;
            full    <= 1'b0;
        end else begin
            credits <= credits + credit_cnt_t'(out_credit) - credit_cnt_t'(out_valid);
            if (result_push) begin
                full <= 1'b1;
            end else if (out_valid) begin
                full <= 1'b0;
            end
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        32'(credits) <= OUT_CREDITS_MAX)
        else $error("downstream granted too many credits: %0d", credits);

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        result_push |-> !full)
        else $error("result pushed into a full output slot");

endmodule

`default_nettype wire

//--- hw/dc_diffuse_ctrl.sv
// Block sequencer for DC error diffusion
`timescale 1ns/1ps
`default_nettype none

module dc_diffuse_ctrl import dc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  mb_in_t    in_mb,
    output logic      in_credit,
    output logic      rd_en,
    output logic      wr_en,
    output logic      first_row,
    output mb_col_t   col,
    input  chan_err_t top_errs [2],
    input  chan_err_t left_errs [2],
    output chan_err_t new_top [2],
    output chan_err_t new_left [2],
    output logic      q_enable,
    output coeff_t    q_coeff_u,
    output coeff_t    q_coeff_v,
    output derr_t     q_top_u,
    output derr_t     q_left_u,
    output derr_t     q_top_v,
    output derr_t     q_left_v,
    input  coeff_t    q_level_u,
    input  coeff_t    q_level_v,
    input  derr_t     q_err_u,
    input  derr_t     q_err_v,
    output logic      result_push,
    output mb_out_t   result,
    input  logic      slot_free
);

    ctrl_state_t     state;
    ctrl_state_t     state_n;
    mb_in_t          mb_q;
    logic [1:0]      blk;
    logic [1:0]      cap_idx;
    chan_err_t       cur_err;
    chan_err_t       nb_top;
    chan_err_t       nb_left;
    chan_err_t [2:0] err_q;
    coeff_t [2:0]    u_lvl;
    coeff_t [2:0]    v_lvl;

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_n = LOAD;
                end
            end
            LOAD:    state_n = BLK0;
            BLK0:    state_n = BLK1;
            BLK1:    state_n = BLK2;
            BLK2:    state_n = BLK3;
            BLK3:    state_n = EMIT;
            EMIT: begin
                if (slot_free) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid) begin
            mb_q <= in_mb;
        end
    end

    // --------------------------------------------------
    // Neighbour selection
    // --------------------------------------------------
    // Quantizer outputs hold the previous block
    assign cur_err = '{u: q_err_u, v: q_err_v};

    always_comb begin
        blk     = 2'd0;
        nb_top  = top_errs[0];
        nb_left = left_errs[0];
        case (state)
            BLK1: begin
                blk     = 2'd1;
                nb_top  = top_errs[1];
                nb_left = cur_err;
            end
            BLK2: begin
                blk     = 2'd2;
                nb_top  = err_q[0];
                nb_left = left_errs[1];
            end
            BLK3: begin
                blk     = 2'd3;
                nb_top  = err_q[1];
                nb_left = cur_err;
            end
            default: ;
        endcase
    end

    assign q_enable  = state inside {BLK0, BLK1, BLK2, BLK3};
    assign q_coeff_u = mb_q.u_dc[blk];
    assign q_coeff_v = mb_q.v_dc[blk];
    assign q_top_u   = nb_top.u;
    assign q_left_u  = nb_left.u;
    assign q_top_v   = nb_top.v;
    assign q_left_v  = nb_left.v;

    // Results of blocks 0 to 2 arrive one state late
    assign cap_idx = blk - 2'd1;

    always_ff @(posedge clk) begin
        if (state inside {BLK1, BLK2, BLK3}) begin
            err_q[cap_idx] <= cur_err;
            u_lvl[cap_idx] <= q_level_u;
            v_lvl[cap_idx] <= q_level_v;
        end
    end

    // --------------------------------------------------
    // Write back and hand off
    // --------------------------------------------------
    assign rd_en       = (state == LOAD);
    assign col         = mb_q.mb_col;
    assign first_row   = mb_q.first_row;
    assign result_push = (state == EMIT) && slot_free;
    assign wr_en       = result_push;
    assign in_credit   = result_push;

    assign new_top[0]  = err_q[2];
    assign new_top[1]  = cur_err;
    assign new_left[0] = err_q[1];
    assign new_left[1] = cur_err;

    assign result.u_level = {q_level_u, u_lvl};
    assign result.v_level = {q_level_v, v_lvl};

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> state == IDLE)
        else $error("macroblock arrived while another is in flight");

endmodule

`default_nettype wire

//--- hw/dc_err_store.sv
// Top row and left error storage
`timescale 1ns/1ps
`default_nettype none

module dc_err_store import dc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rd_en,
    input  mb_col_t   rd_col,
    output chan_err_t top_errs [2],
    output chan_err_t left_errs [2],
    input  logic      wr_en,
    input  mb_col_t   wr_col,
    input  chan_err_t new_top [2],
    input  chan_err_t new_left [2],
    input  logic      first_row
);

    chan_err_t [1:0]        top_mem [MAX_MB_COLS];
    logic [MAX_MB_COLS-1:0] col_written;
    chan_err_t              left_q [2];
    chan_err_t [1:0]        rd_word;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            top_mem[wr_col] <= {new_top[1], new_top[0]};
        end
    end

    // Unwritten columns read back as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_written <= '0;
            left_q      <= '{default: '0};
        end else if (wr_en) begin
            col_written[wr_col] <= 1'b1;
            left_q              <= new_left;
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    assign rd_word = top_mem[rd_col];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < 2; i++) begin
                top_errs[i]  <= (first_row || !col_written[rd_col]) ? '0 : rd_word[i];
                left_errs[i] <= (rd_col == '0) ? '0 : left_q[i];
            end
        end
    end

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !$isunknown(rd_col))
        else $error("error store read column invalid: %0d", rd_col);

endmodule

`default_nettype wire

//--- hw/dc_pkg.sv
// Chroma DC diffusion definitions
`default_nettype none

package dc_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int QFIX            = 17;
    localparam int MAX_MB_COLS     = 64;
    localparam int IN_CREDITS      = 1;
    localparam int OUT_CREDITS_MAX = 4;

    typedef logic signed [15:0] coeff_t;
    typedef logic signed [7:0]  derr_t;
    typedef logic [5:0]         mb_col_t;
    typedef logic [$clog2(OUT_CREDITS_MAX + 1) - 1:0] credit_cnt_t;

    // --------------------------------------------------
    // Grouped signals
    // --------------------------------------------------
    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
    } quant_cfg_t;

    // Blocks in 2x2 order 0 1 / 2 3
    typedef struct packed {
        mb_col_t      mb_col;
        logic         first_row;
        coeff_t [3:0] u_dc;
        coeff_t [3:0] v_dc;
    } mb_in_t;

    typedef struct packed {
        coeff_t [3:0] u_level;
        coeff_t [3:0] v_level;
    } mb_out_t;

    typedef struct packed {
        derr_t u;
        derr_t v;
    } chan_err_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        BLK0,
        BLK1,
        BLK2,
        BLK3,
        EMIT
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/dc_quant_unit.sv
// Single DC quantizer with diffusion
`timescale 1ns/1ps
`default_nettype none

module dc_quant_unit import dc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  coeff_t     coeff,
    input  derr_t      top_err,
    input  derr_t      left_err,
    input  quant_cfg_t cfg,
    output coeff_t     level,
    output derr_t      err
);

    logic signed [11:0] mix;
    logic signed [17:0] corr;
    logic               neg;
    logic        [17:0] mag;
    logic               above;
    logic        [47:0] scaled;
    logic        [15:0] lvl_mag;
    logic        [33:0] qv;
    logic signed [33:0] rem;
    logic signed [33:0] err_s;
    logic signed [33:0] half;
    coeff_t             level_n;
    derr_t              err_n;

    // Seven eighths of top plus all of left
    assign mix  = (top_err * 12'sd7) + (left_err * 12'sd8);
    assign corr = coeff + (mix >>> 3);

    assign neg = corr[17];
    assign mag = neg ? unsigned'(-corr) : unsigned'(corr);

    assign above   = mag > cfg.zthresh;
    assign scaled  = mag * cfg.iq + cfg.bias;
    assign lvl_mag = above ? scaled[QFIX +: 16] : '0;

    // Below threshold the whole magnitude is left over
    assign qv    = lvl_mag * cfg.q;
    assign rem   = $signed({16'd0, mag}) - $signed(qv);
    assign err_s = neg ? -rem : rem;
    assign half  = err_s >>> 1;

    assign level_n = neg ? coeff_t'(-lvl_mag) : coeff_t'(lvl_mag);

    always_comb begin
        if (half > 34'sd127) begin
            err_n = 8'sd127;
        end else if (half < -34'sd128) begin
            err_n = -8'sd128;
        end else begin
            err_n = half[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            level <= level_n;
            err   <= err_n;
        end
    end

    a_level_range: assert property (@(posedge clk) disable iff (!rst_n)
        enable |=> (level > -16'sd2048) && (level < 16'sd2048))
        else $error("quantized DC level out of range: %0d", level);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the chroma DC corrector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dc_corrector -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dc_corrector > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0

//--- tb.f
hw/dc_pkg.sv
hw/dc_quant_unit.sv
hw/dc_err_store.sv
hw/dc_credit_port.sv
hw/dc_diffuse_ctrl.sv
hw/dc_corrector_top.sv
tests/tb_dc_corrector.sv

//--- tests/tb_dc_corrector.sv
// Chroma DC corrector testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dc_corrector import dc_pkg::*; ();

    localparam int Q_VAL       = 20;
    localparam int IQ_VAL      = 6553;
    localparam int BIAS_VAL    = 32768;
    localparam int ZTHRESH_VAL = 30;
    localparam int WAIT_LIMIT  = 200;
    localparam int NUM_MBS     = 12;

    logic       clk;
    logic       rst_n;
    quant_cfg_t cfg;
    logic       in_valid;
    mb_in_t     in_mb;
    logic       in_credit;
    logic       out_valid;
    mb_out_t    out_mb;
    logic       out_credit;

    logic [31:0] lfsr;
    int          top_mem [MAX_MB_COLS][2][2];
    int          left_mem [2][2];
    mb_out_t     exp_arr [16];
    int          wr_ptr;
    int          rd_ptr;
    int          up_credits;
    int          dn_credits;
    logic        quiet_phase;
    logic        timed_phase;

    dc_corrector_top dc_corrector_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .in_valid   (in_valid),
        .in_mb      (in_mb),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_mb     (out_mb),
        .out_credit (out_credit)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic random_coeff(input logic force_small, output coeff_t c);
        int small_sel;
        int raw;
        take_bits(1, small_sel);
        if (force_small || small_sel == 1) begin
            take_bits(5, raw);
            c = coeff_t'(raw - 16);
        end else begin
            take_bits(10, raw);
            c = coeff_t'(raw - 512);
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic void quantize_one(input int coeff, input int top, input int left,
                                         output int level, output int err);
        int     corr;
        int     mag;
        int     lvl;
        int     rem;
        longint scaled;
        corr   = coeff + ((7 * top + 8 * left) >>> 3);
        mag    = (corr < 0) ? -corr : corr;
        scaled = longint'(mag) * IQ_VAL + BIAS_VAL;
        lvl    = (mag > ZTHRESH_VAL) ? int'(scaled >>> QFIX) : 0;
        rem    = mag - lvl * Q_VAL;
        level  = (corr < 0) ? -lvl : lvl;
        err    = ((corr < 0) ? -rem : rem) >>> 1;
        if (err > 127) begin
            err = 127;
        end else if (err < -128) begin
            err = -128;
        end
    endfunction

    // Channel 0 is U and channel 1 is V
    task automatic predict_mb(input mb_in_t mb, output mb_out_t res);
        int col;
        int coeff;
        int lvl;
        int top_e [2];
        int left_e [2];
        int e [4];
        col = int'(mb.mb_col);
        for (int ch = 0; ch < 2; ch++) begin
            for (int k = 0; k < 2; k++) begin
                top_e[k]  = mb.first_row ? 0 : top_mem[col][k][ch];
                left_e[k] = (col == 0) ? 0 : left_mem[k][ch];
            end
            for (int b = 0; b < 4; b++) begin
                coeff = (ch == 0) ? int'(mb.u_dc[b]) : int'(mb.v_dc[b]);
                case (b)
                    0:       quantize_one(coeff, top_e[0], left_e[0], lvl, e[0]);
                    1:       quantize_one(coeff, top_e[1], e[0], lvl, e[1]);
                    2:       quantize_one(coeff, e[0], left_e[1], lvl, e[2]);
                    default: quantize_one(coeff, e[1], e[2], lvl, e[3]);
                endcase
                if (ch == 0) begin
                    res.u_level[b] = coeff_t'(lvl);
                end else begin
                    res.v_level[b] = coeff_t'(lvl);
                end
            end
            top_mem[col][0][ch] = e[2];
            top_mem[col][1][ch] = e[3];
            left_mem[0][ch]     = e[1];
            left_mem[1][ch]     = e[3];
        end
    endtask

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic wait_upstream_credit();
        int cycles;
        cycles = 0;
        while (up_credits == 0) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for an upstream credit");
            end
            step_cycle();
            cycles++;
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (rd_ptr != wr_ptr) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_with_failure("Timed out waiting for outstanding results");
            end
            step_cycle();
            cycles++;
        end
    endtask

    task automatic grant_credit();
        out_credit = 1'b1;
        step_cycle();
        out_credit = 1'b0;
    endtask

    task automatic send_mb(input int row, input int col);
        mb_in_t  mb;
        mb_out_t res;
        coeff_t  c;
        logic    force_small;
        // One interior macroblock of small values only
        force_small  = (row == 1 && col == 1);
        mb.mb_col    = mb_col_t'(col);
        mb.first_row = (row == 0);
        for (int b = 0; b < 4; b++) begin
            random_coeff(force_small, c);
            mb.u_dc[b] = c;
            random_coeff(force_small, c);
            mb.v_dc[b] = c;
        end
        predict_mb(mb, res);
        wait_upstream_credit();
        exp_arr[wr_ptr] = res;
        wr_ptr++;
        in_mb    = mb;
        in_valid = 1'b1;
        step_cycle();
        in_valid = 1'b0;
    endtask

    // --------------------------------------------------
    // Bookkeeping and checks
    // --------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_credits <= IN_CREDITS;
            dn_credits <= 0;
            rd_ptr     <= 0;
        end else begin
            up_credits <= up_credits - int'(in_valid) + int'(in_credit);
            dn_credits <= dn_credits + int'(out_credit) - int'(out_valid);
            if (out_valid) begin
                rd_ptr <= rd_ptr + 1;
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        quiet_phase |-> !out_valid && !in_credit)
        else stop_with_failure($sformatf(
            "ERROR %0t out_valid got %b expected 0, in_credit got %b expected 0",
            $time, $sampled(out_valid), $sampled(in_credit)));

    a_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> dn_credits > 0)
        else stop_with_failure("Output emitted while no downstream credit was held");

    a_up_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        up_credits <= IN_CREDITS)
        else stop_with_failure("Upstream was returned more credits than it spent");

    a_out_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> rd_ptr < wr_ptr)
        else stop_with_failure("Output appeared with no macroblock outstanding");

    a_out_match: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && rd_ptr < wr_ptr |-> out_mb == exp_arr[rd_ptr])
        else stop_with_failure($sformatf("ERROR %0t out_mb got %h expected %h",
            $time, $sampled(out_mb), exp_arr[$sampled(rd_ptr)]));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        timed_phase && $past(in_valid, 7) |-> out_valid)
        else stop_with_failure($sformatf("ERROR %0t out_valid got %b expected 1",
            $time, $sampled(out_valid)));

    a_no_early: assert property (@(posedge clk) disable iff (!rst_n)
        timed_phase && out_valid |-> $past(in_valid, 7))
        else stop_with_failure($sformatf("ERROR %0t out_valid got %b expected 0",
            $time, $sampled(out_valid)));

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_mb       = '0;
        out_credit  = 1'b0;
        cfg         = '{q: 16'(Q_VAL), iq: 16'(IQ_VAL),
                        bias: 32'(BIAS_VAL), zthresh: 32'(ZTHRESH_VAL)};
        lfsr        = 32'hde51_7c22;
        wr_ptr      = 0;
        quiet_phase = 1'b1;
        timed_phase = 1'b0;
        top_mem     = '{default: 0};
        left_mem    = '{default: 0};

        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        repeat (8) step_cycle();
        quiet_phase = 1'b0;

        // Two macroblocks with no downstream credit
        send_mb(0, 0);
        send_mb(0, 1);
        repeat (12) step_cycle();
        grant_credit();
        repeat (4) step_cycle();
        grant_credit();
        wait_drained();

        // Rest of the frame with a spare credit always held
        timed_phase = 1'b1;
        for (int idx = 2; idx < NUM_MBS; idx++) begin
            wait_upstream_credit();
            if (dn_credits - (wr_ptr - rd_ptr) < 1) begin
                grant_credit();
            end
            send_mb(idx / 4, idx % 4);
        end
        wait_drained();
        timed_phase = 1'b0;

        if (up_credits == IN_CREDITS) begin
            $display("TB PASSED");
        end else begin
            stop_with_failure("Upstream credit was not returned after the last macroblock");
        end
        $finish;
    end

endmodule

`default_nettype wire
